// ==== build.f ====
hw/cache_pkg.sv
hw/slow_memory.sv
hw/cache_array.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verif/tb_clock.sv
verif/cache_checker.sv
verif/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_lab

sources:
  - hw/cache_pkg.sv
  - hw/slow_memory.sv
  - hw/cache_array.sv
  - hw/cache_ctrl.sv
  - hw/cache_top.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/cache_checker.sv
      - verif/cache_tb.sv

// ==== verif/cache_tb.sv ====
/* Random read and write traffic over a small block pool to force index conflicts.
   Requests are driven 1 ns after the rising edge and held while proc_stall is high. */
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

    localparam int unsigned lines       = 8;
    localparam int unsigned mem_latency = 4;
    localparam int          n_req       = 600;
    // tags per index in the address pool
    localparam int unsigned tag_pool    = 4;
    localparam int          margin      = 200;
    localparam int          cycle_limit = n_req * (2 * (mem_latency + 3) + 2) + margin;

    logic              clk;
    logic              rst_n;
    proc_req_t         proc_req;
    logic [word_w-1:0] proc_rdata;
    logic              proc_stall;

    int        value_errors;
    int        stall_errors;
    int        completed;
    int        cycle_cnt;
    integer    seed;
    proc_req_t req;

    tb_clock #(
        .period_ns   (100),
        .reset_cycles(2)
    ) clock_i (
        .clk  (clk),
        .rst_n(rst_n)
    );

    cache_top #(
        .lines      (lines),
        .mem_latency(mem_latency)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .proc_req  (proc_req),
        .proc_rdata(proc_rdata),
        .proc_stall(proc_stall)
    );

    cache_checker #(
        .lines      (lines),
        .mem_latency(mem_latency)
    ) checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .proc_req    (proc_req),
        .proc_rdata  (proc_rdata),
        .proc_stall  (proc_stall),
        .value_errors(value_errors),
        .stall_errors(stall_errors),
        .completed   (completed)
    );

    // block = tag * lines + index, so every line sees tag_pool competing blocks
    task automatic make_request(output proc_req_t r);
        int unsigned tag_sel;
        int unsigned idx_sel;
        int unsigned off_sel;
        int unsigned word;
        tag_sel = $unsigned($random(seed)) % tag_pool;
        idx_sel = $unsigned($random(seed)) % lines;
        off_sel = $unsigned($random(seed)) % 4;
        word    = (tag_sel * lines + idx_sel) * 4 + off_sel;
        r       = '0;
        r.addr  = word[word_addr_w-1:0];
        if ($random(seed) & 1) begin
            r.write = 1'b1;
            r.wdata = $random(seed);
        end else begin
            r.read = 1'b1;
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: %0d cycles passed with %0d of %0d requests completed",
                 cycle_cnt, completed, n_req);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed     = 97975;
        proc_req = '0;
        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
        end
        for (int i = 0; i < n_req; i++) begin
            make_request(req);
            #1;
            proc_req = req;
            @(negedge clk);
            // hold until a cycle with stall low
            while (proc_stall) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        #1;
        proc_req = '0;
        repeat (3) @(posedge clk);
        $display("errors: value %0d, stall %0d, completed %0d of %0d requests",
                 value_errors, stall_errors, completed, n_req);
        if (value_errors == 0 && stall_errors == 0 && completed == n_req) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/cache_checker.sv ====
/* Reference model of word memory and direct-mapped residency.
   Each falling edge with a request and stall low counts as one completion. */
`timescale 1ns/1ps
`default_nettype none

module cache_checker import cache_pkg::*; #(
    parameter int unsigned lines       = 8,
    parameter int unsigned mem_latency = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  proc_req_t         proc_req,
    input  logic [word_w-1:0] proc_rdata,
    input  logic              proc_stall,
    output int                value_errors,
    output int                stall_errors,
    output int                completed
);

    logic [word_w-1:0]       model_mem [1 << word_addr_w];
    // full block address kept per line
    logic [block_addr_w-1:0] tag_tbl   [lines];
    logic                    valid_tbl [lines];
    int                      stall_cnt;

    task automatic check_completion();
        logic [block_addr_w-1:0] blk;
        int unsigned             line;
        bit                      resident;
        blk      = proc_req.addr[word_addr_w-1 -: block_addr_w];
        line     = blk % lines;
        resident = valid_tbl[line] && (tag_tbl[line] == blk);
        if (resident && stall_cnt != 0) begin
            stall_errors++;
            $display("unexpected stall: resident block %0d stalled %0d cycles at %0t",
                     blk, stall_cnt, $time);
        end else if (!resident && stall_cnt < int'(mem_latency) + 1) begin
            stall_errors++;
            $display("missing stall: block %0d was not resident but stalled %0d cycles at %0t",
                     blk, stall_cnt, $time);
        end
        if (proc_req.read) begin
            if (proc_rdata !== model_mem[proc_req.addr]) begin
                value_errors++;
                $display("FAIL %0t: read of word %0h returned %h, expected %h",
                         $time, proc_req.addr, proc_rdata, model_mem[proc_req.addr]);
            end
        end else begin
            model_mem[proc_req.addr] = proc_req.wdata;
        end
        // the accessed block is now the one held at its line
        tag_tbl[line]   = blk;
        valid_tbl[line] = 1'b1;
        completed++;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            value_errors = 0;
            stall_errors = 0;
            completed    = 0;
            stall_cnt    = 0;
            for (int w = 0; w < (1 << word_addr_w); w++) begin
                model_mem[w] = '0;
            end
            for (int l = 0; l < lines; l++) begin
                tag_tbl[l]   = '0;
                valid_tbl[l] = 1'b0;
            end
        end else if (proc_req.read || proc_req.write) begin
            if (proc_stall) begin
                stall_cnt++;
            end else begin
                check_completion();
                stall_cnt = 0;
            end
        end else if (proc_stall) begin
            stall_errors++;
            $display("unexpected stall: proc_stall is high with no request at %0t", $time);
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
/* Free-running clock and synchronous reset for the testbench.
   rst_n is released 1 ns after the last reset edge. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
/* Data cache with its slow block memory behind it.
   lines must be a power of two and mem_latency at least 1. */
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int unsigned lines       = 8,
    parameter int unsigned mem_latency = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  proc_req_t         proc_req,
    output logic [word_w-1:0] proc_rdata,
    output logic              proc_stall
);

    localparam int unsigned idx_w = $clog2(lines);
    localparam int unsigned tag_w = block_addr_w - idx_w;

    // controller to array
    logic [idx_w-1:0]   idx;
    logic               wr_en;
    logic [tag_w-1:0]   wr_tag;
    logic [block_w-1:0] wr_data;
    logic               wr_valid;
    logic               wr_dirty;
    logic [tag_w-1:0]   rd_tag;
    logic [block_w-1:0] rd_data;
    logic               rd_valid;
    logic               rd_dirty;

    // controller to memory
    mem_req_t           mem_req;
    logic [block_w-1:0] mem_rdata;
    logic               mem_ready;

    cache_ctrl #(
        .lines(lines)
    ) ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .proc_req  (proc_req),
        .proc_rdata(proc_rdata),
        .proc_stall(proc_stall),
        .idx       (idx),
        .wr_en     (wr_en),
        .wr_tag    (wr_tag),
        .wr_data   (wr_data),
        .wr_valid  (wr_valid),
        .wr_dirty  (wr_dirty),
        .rd_tag    (rd_tag),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_dirty  (rd_dirty),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    cache_array #(
        .lines(lines)
    ) array_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .idx     (idx),
        .wr_en   (wr_en),
        .wr_tag  (wr_tag),
        .wr_data (wr_data),
        .wr_valid(wr_valid),
        .wr_dirty(wr_dirty),
        .rd_tag  (rd_tag),
        .rd_data (rd_data),
        .rd_valid(rd_valid),
        .rd_dirty(rd_dirty)
    );

    slow_memory #(
        .mem_latency(mem_latency)
    ) mem_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready)
    );

endmodule

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
/* Write-back, write-allocate controller that serves one miss at a time.
   The processor must hold proc_req while proc_stall is high. */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; #(
    parameter int unsigned lines = 8,
    localparam int unsigned idx_w = $clog2(lines),
    localparam int unsigned tag_w = block_addr_w - idx_w
) (
    input  logic               clk,
    input  logic               rst_n,
    input  proc_req_t          proc_req,
    output logic [word_w-1:0]  proc_rdata,
    output logic               proc_stall,
    output logic [idx_w-1:0]   idx,
    output logic               wr_en,
    output logic [tag_w-1:0]   wr_tag,
    output logic [block_w-1:0] wr_data,
    output logic               wr_valid,
    output logic               wr_dirty,
    input  logic [tag_w-1:0]   rd_tag,
    input  logic [block_w-1:0] rd_data,
    input  logic               rd_valid,
    input  logic               rd_dirty,
    output mem_req_t           mem_req,
    input  logic [block_w-1:0] mem_rdata,
    input  logic               mem_ready
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // address split
    logic [block_addr_w-1:0] req_blk;
    logic [tag_w-1:0]        req_tag;
    logic [idx_w-1:0]        req_idx;
    logic [offset_w-1:0]     req_off;

    logic               req_active;
    logic               hit;
    logic [block_w-1:0] merged;

    assign req_blk = proc_req.addr[word_addr_w-1 -: block_addr_w];
    assign req_tag = req_blk[block_addr_w-1 -: tag_w];
    assign req_idx = req_blk[idx_w-1:0];
    assign req_off = proc_req.addr[offset_w-1:0];

    // victim and new block share the index
    assign idx = req_idx;

    assign req_active = proc_req.read || proc_req.write;
    assign hit        = rd_valid && (rd_tag == req_tag);

    assign proc_rdata = rd_data[req_off*word_w +: word_w];

    always_comb begin
        merged = rd_data;
        merged[req_off*word_w +: word_w] = proc_req.wdata;
    end

    always_comb begin
        state_d    = state_q;
        proc_stall = 1'b1;
        wr_en      = 1'b0;
        wr_tag     = req_tag;
        wr_data    = merged;
        wr_valid   = 1'b1;
        wr_dirty   = 1'b1;
        mem_req    = '0;

        case (state_q)
            compare: begin
                if (req_active && !hit) begin
                    // only a dirty valid victim needs to go back first
                    if (rd_valid && rd_dirty) begin
                        state_d = write_back;
                    end else begin
                        state_d = allocate;
                    end
                end else begin
                    proc_stall = 1'b0;
                    wr_en      = proc_req.write;
                end
            end
            write_back: begin
                mem_req.write = 1'b1;
                mem_req.addr  = {rd_tag, req_idx};
                mem_req.wdata = rd_data;
                if (mem_ready) begin
                    state_d = allocate;
                end
            end
            allocate: begin
                mem_req.read = 1'b1;
                mem_req.addr = req_blk;
                if (mem_ready) begin
                    // fill clean and let the pending write merge on the next hit
                    wr_en    = 1'b1;
                    wr_data  = mem_rdata;
                    wr_dirty = 1'b0;
                    state_d  = compare;
                end
            end
            default: begin
                state_d = compare;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= compare;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cache_array.sv ====
/* Direct-mapped line store whose lines count must be a power of two and at least 2.
   Reads are combinational at idx and a write updates the whole line at the edge. */
`timescale 1ns/1ps
`default_nettype none

module cache_array import cache_pkg::*; #(
    parameter int unsigned lines = 8,
    localparam int unsigned idx_w = $clog2(lines),
    localparam int unsigned tag_w = block_addr_w - idx_w
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [idx_w-1:0]   idx,
    input  logic               wr_en,
    input  logic [tag_w-1:0]   wr_tag,
    input  logic [block_w-1:0] wr_data,
    input  logic               wr_valid,
    input  logic               wr_dirty,
    output logic [tag_w-1:0]   rd_tag,
    output logic [block_w-1:0] rd_data,
    output logic               rd_valid,
    output logic               rd_dirty
);

    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [block_w-1:0] data;
    } line_t;

    // status bits per line
    logic [lines-1:0] valid_q;
    logic [lines-1:0] dirty_q;

    line_t line_q [lines];
    line_t wr_line;

    assign wr_line.tag  = wr_tag;
    assign wr_line.data = wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[idx] <= wr_valid;
            dirty_q[idx] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_q[idx] <= wr_line;
        end
    end

    assign rd_tag   = line_q[idx].tag;
    assign rd_data  = line_q[idx].data;
    assign rd_valid = valid_q[idx];
    assign rd_dirty = dirty_q[idx];

endmodule

`default_nettype wire

// ==== hw/slow_memory.sv ====
/* Block memory whose fixed latency mem_latency must be at least 1.
   Requests are sampled only in idle, so the requester holds them until mem_ready. */
`timescale 1ns/1ps
`default_nettype none

module slow_memory import cache_pkg::*; #(
    parameter int unsigned mem_latency = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_req_t           mem_req,
    output logic [block_w-1:0] mem_rdata,
    output logic               mem_ready
);

    localparam int unsigned cnt_w = (mem_latency > 1) ? $clog2(mem_latency) : 1;
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(mem_latency - 1);

    mem_state_e         state_q;
    logic [cnt_w-1:0]   cnt_q;
    logic [block_w-1:0] blocks_q [mem_blocks];

    // request as sampled in idle
    mem_req_t           req_q;
    logic [block_w-1:0] rdata_q;

    logic               last_wait;
    logic               do_write;

    assign last_wait = (state_q == wait_lat) && (cnt_q == last_cnt);

    // a write only when read is clear
    assign do_write = req_q.write && !req_q.read;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= idle;
            cnt_q   <= '0;
            for (int b = 0; b < mem_blocks; b++) begin
                blocks_q[b] <= '0;
            end
        end else begin
            case (state_q)
                idle: begin
                    if (mem_req.read || mem_req.write) begin
                        state_q <= wait_lat;
                        cnt_q   <= '0;
                    end
                end
                wait_lat: begin
                    if (last_wait) begin
                        state_q <= ready;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ready: begin
                    // write lands at the edge that ends the ready cycle
                    if (do_write) begin
                        blocks_q[req_q.addr] <= req_q.wdata;
                    end
                    state_q <= idle;
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == idle) begin
            req_q <= mem_req;
        end
    end

    // read block is loaded so it is valid throughout ready
    always_ff @(posedge clk) begin
        if (last_wait && req_q.read) begin
            rdata_q <= blocks_q[req_q.addr];
        end
    end

    assign mem_rdata = rdata_q;
    assign mem_ready = (state_q == ready);

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
/* Shared widths and types for the data cache and its slow block memory.
   A block always holds four words, so the word offset is the low 2 address bits. */
`default_nettype none

package cache_pkg;

    // processor and memory geometry
    localparam int unsigned word_w       = 32;
    localparam int unsigned block_w      = 128;
    localparam int unsigned mem_blocks   = 64;
    localparam int unsigned word_addr_w  = 8;
    localparam int unsigned block_addr_w = 6;

    // word select bits below the block address
    localparam int unsigned offset_w = word_addr_w - block_addr_w;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [word_addr_w-1:0] addr;
        logic [word_w-1:0]      wdata;
    } proc_req_t;

    // read and write are levels, held until mem_ready
    typedef struct packed {
        logic                    read;
        logic                    write;
        logic [block_addr_w-1:0] addr;
        logic [block_w-1:0]      wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        compare    = 2'd0,
        write_back = 2'd1,
        allocate   = 2'd2
    } ctrl_state_e;

    typedef enum logic [1:0] {
        idle     = 2'd0,
        wait_lat = 2'd1,
        ready    = 2'd2
    } mem_state_e;

endpackage

`default_nettype wire
